// ==== hw/cuPkg.sv ====
`default_nettype none

package cuPkg;

  typedef logic [5:0] opcodeT;
  typedef logic [5:0] functT;
  typedef logic [2:0] aluOpT;
  typedef logic [1:0] pcSourceT;
  typedef logic [2:0] addrSelT;
  typedef logic [1:0] regDstT;
  typedef logic [1:0] memToRegT;
  typedef logic [1:0] aluSrcBT;

  // ALU operations
  localparam aluOpT ALU_PASS = 3'b000;
  localparam aluOpT ALU_ADD  = 3'b001;
  localparam aluOpT ALU_SUB  = 3'b010;
  localparam aluOpT ALU_AND  = 3'b011;
  localparam aluOpT ALU_SLT  = 3'b111;

  // PC source mux
  localparam pcSourceT PC_ALU    = 2'b00;
  localparam pcSourceT PC_JUMP   = 2'b01;
  localparam pcSourceT PC_VECTOR = 2'b10;
  localparam pcSourceT PC_TARGET = 2'b11;

  // Memory address mux, the last three are trap vectors
  localparam addrSelT ADDR_PC           = 3'b000;
  localparam addrSelT ADDR_ALUOUT       = 3'b001;
  localparam addrSelT ADDR_VEC_ILLEGAL  = 3'b010;
  localparam addrSelT ADDR_VEC_OVERFLOW = 3'b011;
  localparam addrSelT ADDR_VEC_DIVZERO  = 3'b100;

  localparam regDstT DST_RT = 2'b00;
  localparam regDstT DST_RD = 2'b01;
  localparam regDstT DST_RA = 2'b11;

  localparam memToRegT WB_ALU = 2'b00;
  localparam memToRegT WB_MEM = 2'b01;

  localparam aluSrcBT SRCB_REG       = 2'b00;
  localparam aluSrcBT SRCB_IMM       = 2'b01;
  localparam aluSrcBT SRCB_BRANCHOFS = 2'b10;
  localparam aluSrcBT SRCB_FOUR      = 2'b11;

  // Opcodes
  localparam opcodeT OP_RTYPE = 6'h00;
  localparam opcodeT OP_J     = 6'h02;
  localparam opcodeT OP_JAL   = 6'h03;
  localparam opcodeT OP_BEQ   = 6'h04;
  localparam opcodeT OP_BNE   = 6'h05;
  localparam opcodeT OP_ADDI  = 6'h08;
  localparam opcodeT OP_ADDIU = 6'h09;
  localparam opcodeT OP_SLTI  = 6'h0A;
  localparam opcodeT OP_LW    = 6'h23;
  localparam opcodeT OP_SW    = 6'h2B;

  // Funct codes for opcode 0
  localparam functT FUN_JR   = 6'h08;
  localparam functT FUN_MULT = 6'h18;
  localparam functT FUN_DIV  = 6'h1A;
  localparam functT FUN_ADD  = 6'h20;
  localparam functT FUN_SUB  = 6'h22;
  localparam functT FUN_AND  = 6'h24;
  localparam functT FUN_SLT  = 6'h2A;

  typedef enum logic [3:0] {
    CL_ALU_R, CL_ALU_IMM, CL_LOAD, CL_STORE, CL_BRANCH,
    CL_JUMP, CL_JAL, CL_JR, CL_MULDIV, CL_ILLEGAL
  } instrClassT;

  typedef enum logic [5:0] {
    ST_RESET, ST_FETCH, ST_FETCH_WAIT, ST_DECODE,
    ST_ALU_EXEC, ST_ALU_WB,
    ST_MEM_ADDR, ST_LOAD_READ, ST_LOAD_WB, ST_STORE,
    ST_BRANCH, ST_JUMP, ST_JAL_CALC, ST_JAL_LINK, ST_JR_EXEC, ST_JR_PC,
    ST_MULDIV, ST_TRAP_SAVE, ST_TRAP_VECTOR
  } cuStateT;

endpackage

`default_nettype wire

// ==== hw/decodeIf.sv ====
`default_nettype none

interface decodeIf;
  import cuPkg::*;

  instrClassT instrClass;
  aluOpT      aluOp;
  logic       useImm;
  logic       branchOnEqual;
  // Only meaningful for CL_MULDIV
  logic       isDiv;

  modport drive (output instrClass, aluOp, useImm, branchOnEqual, isDiv);

  modport consume (input instrClass, aluOp, useImm, branchOnEqual, isDiv);

endinterface

`default_nettype wire

// ==== hw/instrDecoder.sv ====
`default_nettype none

module instrDecoder (
  input  cuPkg::opcodeT opcode,
  input  cuPkg::functT  funct,
  decodeIf.drive        dec
);
  import cuPkg::*;

  always_comb begin
    dec.instrClass    = CL_ILLEGAL;
    dec.aluOp         = ALU_ADD;
    dec.useImm        = 1'b0;
    dec.branchOnEqual = 1'b0;
    dec.isDiv         = 1'b0;

    case (opcode)
      OP_RTYPE: begin
        case (funct)
          FUN_ADD: dec.instrClass = CL_ALU_R;
          FUN_SUB: begin
            dec.instrClass = CL_ALU_R;
            dec.aluOp      = ALU_SUB;
          end
          FUN_AND: begin
            dec.instrClass = CL_ALU_R;
            dec.aluOp      = ALU_AND;
          end
          FUN_SLT: begin
            dec.instrClass = CL_ALU_R;
            dec.aluOp      = ALU_SLT;
          end
          FUN_JR:   dec.instrClass = CL_JR;
          FUN_MULT: dec.instrClass = CL_MULDIV;
          FUN_DIV: begin
            dec.instrClass = CL_MULDIV;
            dec.isDiv      = 1'b1;
          end
          default: dec.instrClass = CL_ILLEGAL;
        endcase
      end
      OP_ADDI, OP_ADDIU: begin
        dec.instrClass = CL_ALU_IMM;
        dec.useImm     = 1'b1;
      end
      OP_SLTI: begin
        dec.instrClass = CL_ALU_IMM;
        dec.aluOp      = ALU_SLT;
        dec.useImm     = 1'b1;
      end
      // Address is base plus offset for both
      OP_LW: dec.instrClass = CL_LOAD;
      OP_SW: dec.instrClass = CL_STORE;
      OP_BEQ: begin
        dec.instrClass    = CL_BRANCH;
        dec.aluOp         = ALU_SUB;
        dec.branchOnEqual = 1'b1;
      end
      OP_BNE: begin
        dec.instrClass = CL_BRANCH;
        dec.aluOp      = ALU_SUB;
      end
      OP_J:    dec.instrClass = CL_JUMP;
      OP_JAL:  dec.instrClass = CL_JAL;
      default: dec.instrClass = CL_ILLEGAL;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/mainSequencer.sv ====
`default_nettype none

module mainSequencer (
  input  logic           clk,
  input  logic           reset_in,
  decodeIf.consume       dec,
  input  logic           overflow,
  input  logic           divZero,
  input  logic           mulDivDone,
  output logic           mulDivStart,
  output logic           mulDivIsDivReq,
  output cuPkg::cuStateT state,
  output cuPkg::addrSelT trapVector,
  output cuPkg::aluOpT   aluOpHeld,
  output logic           useImmHeld,
  output logic           branchOnEqualHeld
);
  import cuPkg::*;

  cuStateT stateNext;
  logic    isDivHeld;
  logic    isStoreHeld;
  // High in the first ST_MULDIV cycle only
  logic    mulDivFirst;

  always_comb begin
    stateNext   = state;
    mulDivStart = 1'b0;

    case (state)
      ST_RESET:      stateNext = ST_FETCH;
      ST_FETCH:      stateNext = ST_FETCH_WAIT;
      ST_FETCH_WAIT: stateNext = ST_DECODE;
      ST_DECODE: begin
        case (dec.instrClass)
          CL_ALU_R, CL_ALU_IMM: stateNext = ST_ALU_EXEC;
          CL_LOAD, CL_STORE:    stateNext = ST_MEM_ADDR;
          CL_BRANCH:            stateNext = ST_BRANCH;
          CL_JUMP:              stateNext = ST_JUMP;
          CL_JAL:               stateNext = ST_JAL_CALC;
          CL_JR:                stateNext = ST_JR_EXEC;
          CL_MULDIV:            stateNext = ST_MULDIV;
          default:              stateNext = ST_TRAP_SAVE;
        endcase
      end
      ST_ALU_EXEC:  stateNext = ST_ALU_WB;
      ST_ALU_WB:    stateNext = overflow ? ST_TRAP_SAVE : ST_FETCH;
      ST_MEM_ADDR:  stateNext = isStoreHeld ? ST_STORE : ST_LOAD_READ;
      ST_LOAD_READ: stateNext = ST_LOAD_WB;
      ST_LOAD_WB:   stateNext = ST_FETCH;
      ST_STORE:     stateNext = ST_FETCH;
      ST_BRANCH:    stateNext = ST_FETCH;
      ST_JUMP:      stateNext = ST_FETCH;
      ST_JAL_CALC:  stateNext = ST_JAL_LINK;
      ST_JAL_LINK:  stateNext = ST_JUMP;
      ST_JR_EXEC:   stateNext = ST_JR_PC;
      ST_JR_PC:     stateNext = ST_FETCH;
      ST_MULDIV: begin
        if (mulDivFirst) begin
          // Divide by zero never reaches the unit
          if (isDivHeld && divZero) begin
            stateNext = ST_TRAP_SAVE;
          end else begin
            mulDivStart = 1'b1;
          end
        end else if (mulDivDone) begin
          stateNext = ST_FETCH;
        end
      end
      ST_TRAP_SAVE:   stateNext = ST_TRAP_VECTOR;
      ST_TRAP_VECTOR: stateNext = ST_FETCH;
      default:        stateNext = ST_FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_in) begin
      state       <= ST_RESET;
      mulDivFirst <= 1'b0;
      trapVector  <= ADDR_VEC_ILLEGAL;
    end else begin
      state       <= stateNext;
      mulDivFirst <= (state == ST_DECODE) && (stateNext == ST_MULDIV);
      // Trap cause follows from where the trap was taken
      if (stateNext == ST_TRAP_SAVE) begin
        case (state)
          ST_ALU_WB: trapVector <= ADDR_VEC_OVERFLOW;
          ST_MULDIV: trapVector <= ADDR_VEC_DIVZERO;
          default:   trapVector <= ADDR_VEC_ILLEGAL;
        endcase
      end
    end
  end

  // Instruction fields kept for the execute states
  always_ff @(posedge clk) begin
    if (state == ST_DECODE) begin
      aluOpHeld         <= dec.aluOp;
      useImmHeld        <= dec.useImm;
      branchOnEqualHeld <= dec.branchOnEqual;
      isDivHeld         <= dec.isDiv;
      isStoreHeld       <= (dec.instrClass == CL_STORE);
    end
  end

  assign mulDivIsDivReq = isDivHeld;

endmodule

`default_nettype wire

// ==== hw/controlEncoder.sv ====
`default_nettype none

module controlEncoder (
  input  cuPkg::cuStateT   state,
  input  cuPkg::addrSelT   trapVector,
  input  cuPkg::aluOpT     aluOpHeld,
  input  logic             useImmHeld,
  input  logic             branchOnEqualHeld,
  output logic             pcWrite,
  output logic             pcWriteCond,
  output logic             branchOnEqual,
  output cuPkg::pcSourceT  pcSource,
  output cuPkg::addrSelT   iorD,
  output logic             memRead,
  output logic             memWrite,
  output logic             irWrite,
  output logic             regWrite,
  output cuPkg::regDstT    regDst,
  output cuPkg::memToRegT  memToReg,
  output logic             aluSrcA,
  output cuPkg::aluSrcBT   aluSrcB,
  output cuPkg::aluOpT     aluOp
);
  import cuPkg::*;

  always_comb begin
    pcWrite       = 1'b0;
    pcWriteCond   = 1'b0;
    branchOnEqual = 1'b0;
    pcSource      = PC_ALU;
    iorD          = ADDR_PC;
    memRead       = 1'b0;
    memWrite      = 1'b0;
    irWrite       = 1'b0;
    regWrite      = 1'b0;
    regDst        = DST_RT;
    memToReg      = WB_ALU;
    aluSrcA       = 1'b0;
    aluSrcB       = SRCB_REG;
    aluOp         = ALU_PASS;

    case (state)
      // PC+4 goes straight back into the PC
      ST_FETCH: begin
        memRead = 1'b1;
        irWrite = 1'b1;
        pcWrite = 1'b1;
        aluSrcB = SRCB_FOUR;
        aluOp   = ALU_ADD;
      end
      // Branch target lands in ALUOut
      ST_DECODE: begin
        aluSrcB = SRCB_BRANCHOFS;
        aluOp   = ALU_ADD;
      end
      ST_ALU_EXEC: begin
        aluSrcA = 1'b1;
        aluSrcB = useImmHeld ? SRCB_IMM : SRCB_REG;
        aluOp   = aluOpHeld;
      end
      ST_ALU_WB: begin
        regWrite = 1'b1;
        regDst   = useImmHeld ? DST_RT : DST_RD;
      end
      ST_MEM_ADDR: begin
        aluSrcA = 1'b1;
        aluSrcB = SRCB_IMM;
        aluOp   = ALU_ADD;
      end
      ST_LOAD_READ: begin
        memRead = 1'b1;
        iorD    = ADDR_ALUOUT;
      end
      ST_LOAD_WB: begin
        regWrite = 1'b1;
        memToReg = WB_MEM;
      end
      ST_STORE: begin
        memWrite = 1'b1;
        iorD     = ADDR_ALUOUT;
      end
      // Compare by subtraction, target taken from ALUOut
      ST_BRANCH: begin
        pcWriteCond   = 1'b1;
        branchOnEqual = branchOnEqualHeld;
        pcSource      = PC_TARGET;
        aluSrcA       = 1'b1;
        aluOp         = ALU_SUB;
      end
      ST_JAL_CALC: begin
        aluSrcB = SRCB_FOUR;
        aluOp   = ALU_ADD;
      end
      ST_JAL_LINK: begin
        regWrite = 1'b1;
        regDst   = DST_RA;
      end
      ST_JUMP: begin
        pcWrite  = 1'b1;
        pcSource = PC_JUMP;
      end
      ST_JR_EXEC: aluSrcA = 1'b1;
      ST_JR_PC: begin
        pcWrite  = 1'b1;
        pcSource = PC_TARGET;
      end
      ST_TRAP_VECTOR: begin
        memRead  = 1'b1;
        iorD     = trapVector;
        pcWrite  = 1'b1;
        pcSource = PC_VECTOR;
      end
      // Reset, fetch wait, mul/div wait and trap save drive nothing
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/mulDivHandshake.sv ====
`default_nettype none

module mulDivHandshake (
  input  logic clk,
  input  logic reset_in,
  input  logic start,
  input  logic isDiv,
  output logic done,
  output logic mulDivReq,
  output logic mulDivIsDiv,
  input  logic mulDivAck
);

  typedef enum logic [1:0] {
    HS_IDLE,
    HS_WAIT_ACK,
    HS_WAIT_RELEASE
  } hsStateT;

  hsStateT hsState;
  logic    isDivLatched;

  always_ff @(posedge clk) begin
    if (reset_in) begin
      hsState <= HS_IDLE;
    end else begin
      case (hsState)
        HS_IDLE:         if (start) hsState <= HS_WAIT_ACK;
        HS_WAIT_ACK:     if (mulDivAck) hsState <= HS_WAIT_RELEASE;
        HS_WAIT_RELEASE: if (!mulDivAck) hsState <= HS_IDLE;
        default:         hsState <= HS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start && (hsState == HS_IDLE)) begin
      isDivLatched <= isDiv;
    end
  end

  // Request straight from the state register
  assign mulDivReq   = (hsState == HS_WAIT_ACK);
  assign mulDivIsDiv = isDivLatched;
  assign done        = (hsState == HS_WAIT_RELEASE) && !mulDivAck;

endmodule

`default_nettype wire

// ==== hw/controlUnit.sv ====
`default_nettype none

module controlUnit (
  input  logic             clk,
  input  logic             reset_in,
  input  cuPkg::opcodeT    opcode,
  input  cuPkg::functT     funct,
  input  logic             overflow,
  input  logic             divZero,
  input  logic             mulDivAck,
  output logic             mulDivReq,
  output logic             mulDivIsDiv,
  output logic             pcWrite,
  output logic             pcWriteCond,
  output logic             branchOnEqual,
  output cuPkg::pcSourceT  pcSource,
  output cuPkg::addrSelT   iorD,
  output logic             memRead,
  output logic             memWrite,
  output logic             irWrite,
  output logic             regWrite,
  output cuPkg::regDstT    regDst,
  output cuPkg::memToRegT  memToReg,
  output logic             aluSrcA,
  output cuPkg::aluSrcBT   aluSrcB,
  output cuPkg::aluOpT     aluOp
);
  import cuPkg::*;

  cuStateT state;
  addrSelT trapVector;
  aluOpT   aluOpHeld;
  logic    useImmHeld;
  logic    branchOnEqualHeld;
  logic    mulDivStart;
  logic    mulDivIsDivReq;
  logic    mulDivDone;

  decodeIf decBus ();

  instrDecoder decoder_i (
    .opcode (opcode),
    .funct  (funct),
    .dec    (decBus.drive)
  );

  mainSequencer sequencer_i (
    .clk               (clk),
    .reset_in          (reset_in),
    .dec               (decBus.consume),
    .overflow          (overflow),
    .divZero           (divZero),
    .mulDivDone        (mulDivDone),
    .mulDivStart       (mulDivStart),
    .mulDivIsDivReq    (mulDivIsDivReq),
    .state             (state),
    .trapVector        (trapVector),
    .aluOpHeld         (aluOpHeld),
    .useImmHeld        (useImmHeld),
    .branchOnEqualHeld (branchOnEqualHeld)
  );

  controlEncoder encoder_i (
    .state             (state),
    .trapVector        (trapVector),
    .aluOpHeld         (aluOpHeld),
    .useImmHeld        (useImmHeld),
    .branchOnEqualHeld (branchOnEqualHeld),
    .pcWrite           (pcWrite),
    .pcWriteCond       (pcWriteCond),
    .branchOnEqual     (branchOnEqual),
    .pcSource          (pcSource),
    .iorD              (iorD),
    .memRead           (memRead),
    .memWrite          (memWrite),
    .irWrite           (irWrite),
    .regWrite          (regWrite),
    .regDst            (regDst),
    .memToReg          (memToReg),
    .aluSrcA           (aluSrcA),
    .aluSrcB           (aluSrcB),
    .aluOp             (aluOp)
  );

  mulDivHandshake handshake_i (
    .clk         (clk),
    .reset_in    (reset_in),
    .start       (mulDivStart),
    .isDiv       (mulDivIsDivReq),
    .done        (mulDivDone),
    .mulDivReq   (mulDivReq),
    .mulDivIsDiv (mulDivIsDiv),
    .mulDivAck   (mulDivAck)
  );

endmodule

`default_nettype wire

// ==== bench/cuChecker.sv ====
`default_nettype none

module cuChecker (
  input  logic            clk,
  input  logic            reset_in,
  input  cuPkg::opcodeT   opcode,
  input  cuPkg::functT    funct,
  input  logic            overflow,
  input  logic            divZero,
  input  logic            mulDivAck,
  input  logic            mulDivReq,
  input  logic            mulDivIsDiv,
  input  logic            pcWrite,
  input  logic            pcWriteCond,
  input  logic            branchOnEqual,
  input  cuPkg::pcSourceT pcSource,
  input  cuPkg::addrSelT  iorD,
  input  logic            memRead,
  input  logic            memWrite,
  input  logic            irWrite,
  input  logic            regWrite,
  input  cuPkg::regDstT   regDst,
  input  cuPkg::memToRegT memToReg,
  input  logic            aluSrcA,
  input  cuPkg::aluSrcBT  aluSrcB,
  input  cuPkg::aluOpT    aluOp,
  output int              testsDone,
  output int              testsFailed,
  output int              errorCount
);
  timeunit 1ns;
  timeprecision 1ns;
  import cuPkg::*;

  typedef enum {
    K_RESET, K_ALU, K_LOAD, K_STORE, K_BRANCH,
    K_JUMP, K_JAL, K_JR, K_MULDIV, K_ILLEGAL
  } kindT;

  kindT    kind         = K_RESET;
  string   testName     = "reset";
  int      step         = 0;
  int      expLen       = 0;
  int      trapStep     = -1;
  int      testErrors   = 0;
  int      doneCount    = 0;
  int      failedCount  = 0;
  int      errCount     = 0;
  addrSelT trapVec      = ADDR_VEC_ILLEGAL;
  aluOpT   expAluOp     = ALU_ADD;
  logic    expImm       = 1'b0;
  logic    expEqual     = 1'b0;
  logic    expDiv       = 1'b0;
  logic    ackSeen      = 1'b0;
  logic    prevReq      = 1'b0;
  logic    wasReset     = 1'b0;
  logic    resetPending = 1'b0;
  // pcWrite, pcWriteCond, memRead, memWrite, irWrite, regWrite
  logic [5:0] enables;

  assign testsDone   = doneCount;
  assign testsFailed = failedCount;
  assign errorCount  = errCount;

  task automatic compareValue(input string field, input int expected, input int actual);
    if (expected != actual) begin
      $display("FAIL %s %s: expected %0h, actual %0h", testName, field, expected, actual);
      errCount++;
      testErrors++;
    end
  endtask

  task automatic reportProblem(input string what);
    $display("ERROR %s: %s", testName, what);
    errCount++;
    testErrors++;
  endtask

  task automatic finishTest();
    if (kind != K_RESET) begin
      compareValue("length", expLen, step + 1);
    end
    if (testErrors == 0) begin
      $display("done %s: ok", testName);
    end else begin
      $display("done %s: %0d errors", testName, testErrors);
      failedCount++;
    end
    doneCount++;
  endtask

  // Classify the new instruction from its opcode and funct
  task automatic startTest();
    kind     = K_ILLEGAL;
    expAluOp = ALU_ADD;
    expImm   = 1'b0;
    expEqual = 1'b0;
    expDiv   = 1'b0;
    ackSeen  = 1'b0;
    trapStep = -1;
    expLen   = 0;
    case (opcode)
      OP_RTYPE: begin
        case (funct)
          FUN_ADD: kind = K_ALU;
          FUN_SUB: begin
            kind     = K_ALU;
            expAluOp = ALU_SUB;
          end
          FUN_AND: begin
            kind     = K_ALU;
            expAluOp = ALU_AND;
          end
          FUN_SLT: begin
            kind     = K_ALU;
            expAluOp = ALU_SLT;
          end
          FUN_JR:   kind = K_JR;
          FUN_MULT: kind = K_MULDIV;
          FUN_DIV: begin
            kind   = K_MULDIV;
            expDiv = 1'b1;
          end
          default: ;
        endcase
      end
      OP_ADDI, OP_ADDIU: begin
        kind   = K_ALU;
        expImm = 1'b1;
      end
      OP_SLTI: begin
        kind     = K_ALU;
        expImm   = 1'b1;
        expAluOp = ALU_SLT;
      end
      OP_LW:  kind = K_LOAD;
      OP_SW:  kind = K_STORE;
      OP_BEQ: begin
        kind     = K_BRANCH;
        expEqual = 1'b1;
      end
      OP_BNE:  kind = K_BRANCH;
      OP_J:    kind = K_JUMP;
      OP_JAL:  kind = K_JAL;
      default: ;
    endcase
    case (kind)
      K_ALU, K_STORE, K_JR: expLen = 5;
      K_LOAD, K_JAL:        expLen = 6;
      K_BRANCH, K_JUMP:     expLen = 4;
      K_ILLEGAL: begin
        expLen   = 5;
        trapStep = 3;
        trapVec  = ADDR_VEC_ILLEGAL;
      end
      default: ;
    endcase
    testName = $sformatf("#%0d %s op %02h funct %02h", doneCount, kind.name(), opcode, funct);
  endtask

  task automatic checkStep();
    logic [5:0] expEnables;
    expEnables = 6'b000000;
    if (trapStep >= 0 && step == trapStep + 1) begin
      expEnables = 6'b101000;
      compareValue("iorD", int'(trapVec), int'(iorD));
      compareValue("pcSource", int'(PC_VECTOR), int'(pcSource));
    end else if (trapStep < 0 || step < trapStep) begin
      case (kind)
        K_ALU: begin
          if (step == 3) begin
            compareValue("aluOp", int'(expAluOp), int'(aluOp));
            compareValue("aluSrcA", 1, int'(aluSrcA));
            compareValue("aluSrcB", int'(expImm ? SRCB_IMM : SRCB_REG), int'(aluSrcB));
          end else if (step == 4) begin
            expEnables = 6'b000001;
            compareValue("memToReg", int'(WB_ALU), int'(memToReg));
            compareValue("regDst", int'(expImm ? DST_RT : DST_RD), int'(regDst));
            if (overflow) begin
              trapStep = 5;
              trapVec  = ADDR_VEC_OVERFLOW;
              expLen   = 7;
            end
          end
        end
        K_LOAD: begin
          if (step == 4) begin
            expEnables = 6'b001000;
            compareValue("iorD", int'(ADDR_ALUOUT), int'(iorD));
          end else if (step == 5) begin
            expEnables = 6'b000001;
            compareValue("memToReg", int'(WB_MEM), int'(memToReg));
            compareValue("regDst", int'(DST_RT), int'(regDst));
          end
        end
        K_STORE: begin
          if (step == 4) begin
            expEnables = 6'b000100;
            compareValue("iorD", int'(ADDR_ALUOUT), int'(iorD));
          end
        end
        K_BRANCH: begin
          if (step == 3) begin
            expEnables = 6'b010000;
            compareValue("branchOnEqual", int'(expEqual), int'(branchOnEqual));
          end
        end
        K_JUMP: begin
          if (step == 3) begin
            expEnables = 6'b100000;
            compareValue("pcSource", int'(PC_JUMP), int'(pcSource));
          end
        end
        K_JAL: begin
          if (step == 4) begin
            expEnables = 6'b000001;
            compareValue("regDst", int'(DST_RA), int'(regDst));
          end else if (step == 5) begin
            expEnables = 6'b100000;
            compareValue("pcSource", int'(PC_JUMP), int'(pcSource));
          end
        end
        K_JR: begin
          if (step == 4) begin
            expEnables = 6'b100000;
            compareValue("pcSource", int'(PC_TARGET), int'(pcSource));
          end
        end
        // Divide by zero is decided in the first wait cycle
        K_MULDIV: begin
          if (step == 3 && expDiv && divZero) begin
            trapStep = 4;
            trapVec  = ADDR_VEC_DIVZERO;
            expLen   = 6;
          end
        end
        default: ;
      endcase
    end
    if (expLen != 0 && step == expLen) begin
      expEnables[1] = 1'b1;
    end
    compareValue("enables", int'(expEnables), int'(enables));
  endtask

  // Request runs from the cycle after start until the cycle ack is seen
  task automatic checkHandshake();
    logic expReq;
    expReq = (kind == K_MULDIV) && (trapStep < 0) && (step >= 4) && !ackSeen;
    compareValue("mulDivReq", int'(expReq), int'(mulDivReq));
    if (mulDivReq) begin
      compareValue("mulDivIsDiv", int'(expDiv), int'(mulDivIsDiv));
    end
    if (mulDivReq && !prevReq && mulDivAck) begin
      reportProblem("mulDivReq rose while mulDivAck was still high");
    end
    if (kind == K_MULDIV && trapStep < 0 && step >= 4) begin
      if (mulDivAck) begin
        ackSeen = 1'b1;
      end else if (ackSeen && expLen == 0) begin
        expLen = step + 1;
      end
    end
    prevReq = mulDivReq;
  endtask

  always @(negedge clk) begin
    enables = {pcWrite, pcWriteCond, memRead, memWrite, irWrite, regWrite};
    // State stays ST_RESET until reset_in is sampled low
    if (reset_in || resetPending) begin
      compareValue("enables", 0, int'(enables));
      compareValue("mulDivReq", 0, int'(mulDivReq));
      wasReset     = !reset_in;
      resetPending = reset_in;
    end else if (irWrite) begin
      finishTest();
      testErrors = 0;
      testName   = $sformatf("#%0d fetch", doneCount);
      compareValue("enables", int'(6'b101010), int'(enables));
      compareValue("iorD", int'(ADDR_PC), int'(iorD));
      compareValue("aluSrcA", 0, int'(aluSrcA));
      compareValue("aluSrcB", int'(SRCB_FOUR), int'(aluSrcB));
      compareValue("aluOp", int'(ALU_ADD), int'(aluOp));
      compareValue("mulDivReq", 0, int'(mulDivReq));
      step     = 0;
      wasReset = 1'b0;
    end else begin
      if (wasReset) begin
        reportProblem("the first cycle after reset is not a fetch");
      end
      wasReset = 1'b0;
      step++;
      if (step == 1) begin
        startTest();
      end
      checkStep();
      checkHandshake();
    end
  end

endmodule

`default_nettype wire

// ==== bench/tbControlUnit.sv ====
`default_nettype none

module tbControlUnit;
  timeunit 1ns;
  timeprecision 1ns;
  import cuPkg::*;

  localparam int NUM_TESTS      = 400;
  localparam int TIMEOUT_CYCLES = 20000;

  logic     clk         = 1'b0;
  logic     reset_in    = 1'b1;
  opcodeT   opcode      = OP_RTYPE;
  functT    funct       = FUN_ADD;
  logic     overflow    = 1'b0;
  logic     divZero     = 1'b0;
  logic     mulDivAck   = 1'b0;
  logic     mulDivReq;
  logic     mulDivIsDiv;
  logic     pcWrite;
  logic     pcWriteCond;
  logic     branchOnEqual;
  pcSourceT pcSource;
  addrSelT  iorD;
  logic     memRead;
  logic     memWrite;
  logic     irWrite;
  logic     regWrite;
  regDstT   regDst;
  memToRegT memToReg;
  logic     aluSrcA;
  aluSrcBT  aluSrcB;
  aluOpT    aluOp;

  logic [31:0] lfsr        = 32'd71290;
  logic        seenIrWrite = 1'b0;
  logic        seenReq     = 1'b0;
  int          ackWait     = 0;
  int          cycles      = 0;
  logic        timedOut    = 1'b0;
  int          testsDone;
  int          testsFailed;
  int          errorCount;

  always #50 clk = ~clk;

  controlUnit dut_i (.*);

  cuChecker checker_i (.*);

  // One LFSR step per bit, bits come out MSB first
  function automatic int randomBits(input int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BCD35C) : (lfsr >> 1);
    end
    return value;
  endfunction

  task automatic driveNextInstruction();
    int pick;
    pick = randomBits(4);
    opcode <= OP_RTYPE;
    funct  <= functT'(randomBits(6));
    case (pick)
      0:  funct <= FUN_ADD;
      1:  funct <= FUN_SUB;
      2:  funct <= FUN_AND;
      3:  funct <= FUN_SLT;
      4:  opcode <= OP_ADDI;
      5:  opcode <= OP_ADDIU;
      6:  opcode <= OP_SLTI;
      7:  opcode <= OP_LW;
      8:  opcode <= OP_SW;
      9:  opcode <= OP_BEQ;
      10: opcode <= OP_BNE;
      11: opcode <= OP_J;
      12: opcode <= OP_JAL;
      13: funct <= FUN_JR;
      14: funct <= (randomBits(1) == 1) ? FUN_DIV : FUN_MULT;
      // Mostly unused opcodes
      default: opcode <= opcodeT'(randomBits(6));
    endcase
  endtask

  always @(negedge clk) begin
    seenIrWrite <= irWrite;
    seenReq     <= mulDivReq;
  end

  always @(posedge clk) begin
    overflow <= (randomBits(2) == 3);
    divZero  <= (randomBits(1) == 1);
    if (reset_in) begin
      mulDivAck <= 1'b0;
      ackWait = randomBits(3);
    end else begin
      if (seenIrWrite) begin
        driveNextInstruction();
      end
      // Ack follows req after a random delay, both edges
      if (seenReq != mulDivAck) begin
        if (ackWait == 0) begin
          mulDivAck <= seenReq;
          ackWait = randomBits(3);
        end else begin
          ackWait--;
        end
      end
    end
  end

  initial begin
    repeat (5) @(posedge clk);
    reset_in <= 1'b0;
    while (testsDone < NUM_TESTS && !timedOut) begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        timedOut = 1'b1;
      end
    end
    if (timedOut) begin
      $display("Timeout: %0d of %0d instructions finished in %0d cycles",
               testsDone, NUM_TESTS, cycles);
    end
    $display("Tests run %0d, failed %0d, mismatches %0d", testsDone, testsFailed, errorCount);
    if (timedOut || errorCount != 0 || testsFailed != 0) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/cuPkg.sv
hw/decodeIf.sv
hw/instrDecoder.sv
hw/mainSequencer.sv
hw/controlEncoder.sv
hw/mulDivHandshake.sv
hw/controlUnit.sv
bench/cuChecker.sv
bench/tbControlUnit.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ns -j 0 \
    --top-module tbControlUnit -f sources.f -o simControlUnit; then
  echo "Verilator build failed"
  exit 1
fi

if ! output=$(./obj_dir/simControlUnit); then
  echo "$output"
  echo "Simulation exited with an error"
  exit 1
fi
echo "$output"

if echo "$output" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1
